//--- hdl/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width
`define ALU_WORD_WIDTH 16

// Shift amount width, log2 of the word width
`define ALU_SHAMT_WIDTH 4

// Bits per first level lookahead group
`define ALU_LA_GROUP 4

`endif

//--- hdl/alu_pkg.sv
`default_nettype none
`include "alu_cfg.svh"

package alu_pkg;

	// Which compute block answers the request
	typedef enum logic [1:0] {
		UNIT_ADD,
		UNIT_CMP,
		UNIT_SHIFT
	} unit_t;

	// Fill source for the vacated bits
	typedef enum logic [1:0] {
		SHIFT_LOGIC,
		SHIFT_ARITH,
		SHIFT_DOUBLE, // Bits come from the fill operand
		SHIFT_CYCLIC
	} shift_type_t;

	typedef struct packed {
		logic signed_mode; // Signed compare
		logic subtract;    // Invert b before the add
		logic carry_in;
	} arith_ctl_t;

	typedef struct packed {
		logic left;
		shift_type_t shift_type;
	} shift_ctl_t;

	// One control word, two readings
	typedef union packed {
		arith_ctl_t arith;
		shift_ctl_t shift;
	} op_ctl_u;

	typedef logic [`ALU_WORD_WIDTH-1:0] word_t;

	typedef struct packed {
		unit_t unit;
		op_ctl_u ctl;
		word_t a;
		word_t b; // Also the fill word for double precision shifts
		logic [`ALU_SHAMT_WIDTH-1:0] shamt;
	} alu_req_t;

	typedef struct packed {
		word_t result;
		logic carry;
		logic overflow; // Signed overflow of the add
		logic above;
		logic below;
		logic zero;     // Result word is all zeros
	} alu_resp_t;

endpackage

`default_nettype wire

//--- hdl/cla_adder.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_cfg.svh"

module cla_adder import alu_pkg::*; (
	input wire word_t a,
	input wire word_t b,
	input wire carry_in,
	output word_t sum,
	output logic carry_out,
	output logic overflow
);
	localparam int WIDTH = `ALU_WORD_WIDTH;
	localparam int GROUP = `ALU_LA_GROUP;
	localparam int NUM_GROUPS = WIDTH / GROUP;

	// Carries into positions 0..n of an n-bit slice
	// Each carry is a flat sum of products, no rippling
	function automatic logic [WIDTH:0] lookahead(
		input word_t p,
		input word_t g,
		input logic cin,
		input int n
	);
		logic [WIDTH:0] c;
		logic term;
		c = '0;
		c[0] = cin;
		for (int j = 0; j < n; j++) begin
			c[j + 1] = cin; // Carry in propagated through all bits below
			for (int k = 0; k <= j; k++) begin
				c[j + 1] &= p[k];
			end
			for (int k = 0; k <= j; k++) begin
				term = g[k]; // Generated at k, propagated up to j
				for (int m = k + 1; m <= j; m++) begin
					term &= p[m];
				end
				c[j + 1] |= term;
			end
		end
		return c;
	endfunction

	word_t prop;  // Bit propagate, also the half sum
	word_t gen;   // Bit generate
	word_t carry; // Carry into each bit
	logic [NUM_GROUPS-1:0] grp_prop;
	logic [NUM_GROUPS-1:0] grp_gen;
	logic [WIDTH:0] grp_carry; // Carries into groups, top one is carry out

	assign prop = a ^ b;
	assign gen = a & b;

	for (genvar gi = 0; gi < NUM_GROUPS; gi++) begin : group
		word_t p_slice;
		word_t g_slice;
		logic [WIDTH:0] free_carry;  // Group carries with zero carry in
		logic [WIDTH:0] local_carry;
		assign p_slice = word_t'(prop[gi*GROUP +: GROUP]);
		assign g_slice = word_t'(gen[gi*GROUP +: GROUP]);
		assign free_carry = lookahead(p_slice, g_slice, 1'b0, GROUP);
		assign grp_prop[gi] = &prop[gi*GROUP +: GROUP];
		assign grp_gen[gi] = free_carry[GROUP]; // Group generates on its own
		assign local_carry = lookahead(p_slice, g_slice, grp_carry[gi], GROUP);
		assign carry[gi*GROUP +: GROUP] = local_carry[GROUP-1:0];
	end

	// Second level over the groups
	assign grp_carry = lookahead(word_t'(grp_prop), word_t'(grp_gen), carry_in, NUM_GROUPS);

	assign sum = prop ^ carry;
	assign carry_out = grp_carry[NUM_GROUPS];
	assign overflow = carry_out ^ carry[WIDTH-1]; // Into MSB differs from out of MSB

endmodule

`default_nettype wire

//--- hdl/magnitude_comparator.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_cfg.svh"

module magnitude_comparator import alu_pkg::*; (
	input wire word_t a,
	input wire word_t b,
	output logic above, // a > b
	output logic below  // a < b
);
	localparam int LEVELS = $clog2(`ALU_WORD_WIDTH);
	localparam int LEAVES = 2 ** LEVELS; // Word padded up to a power of two

	// Row 0 holds the per-bit terms, row LEVELS the root
	logic [LEVELS:0][LEAVES-1:0] above_tree;
	logic [LEVELS:0][LEAVES-1:0] below_tree;

	// Padding bits compare equal
	assign above_tree[0] = LEAVES'(a & ~b);
	assign below_tree[0] = LEAVES'(~a & b);

	for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : level
		localparam int NODES = LEAVES >> (lvl + 1);

		for (genvar n = 0; n < NODES; n++) begin : node
			logic hi_above;
			logic hi_below;
			logic lo_above;
			logic lo_below;

			assign hi_above = above_tree[lvl][2*n + 1];
			assign hi_below = below_tree[lvl][2*n + 1];
			assign lo_above = above_tree[lvl][2*n];
			assign lo_below = below_tree[lvl][2*n];

			// Upper half decides unless it is equal
			assign above_tree[lvl + 1][n] = hi_above | (~hi_below & lo_above);
			assign below_tree[lvl + 1][n] = hi_below | (~hi_above & lo_below);
		end

		// Row narrows by half each level
		assign above_tree[lvl + 1][LEAVES-1:NODES] = '0;
		assign below_tree[lvl + 1][LEAVES-1:NODES] = '0;
	end

	// Equal when neither is set
	assign above = above_tree[LEVELS][0];
	assign below = below_tree[LEVELS][0];

endmodule

`default_nettype wire

//--- hdl/polyshifter.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_cfg.svh"

module polyshifter import alu_pkg::*; (
	input wire word_t data,
	input wire word_t fill,                    // Incoming bits for double precision
	input wire [`ALU_SHAMT_WIDTH-1:0] shamt,
	input wire shift_ctl_t ctl,
	output word_t shifted
);
	localparam int WIDTH = `ALU_WORD_WIDTH;

	// Bits that enter from the left on a right shift, LSB enters first
	logic [WIDTH-2:0] right_arg;
	// Bits that enter from the right on a left shift, MSB enters first
	logic [WIDTH-2:0] left_arg;

	// Every shifted version of the word, indexed by amount
	logic [WIDTH-1:0][WIDTH-1:0] right_cand;
	logic [WIDTH-1:0][WIDTH-1:0] left_cand;

	// Mode multiplexer
	always_comb begin
		right_arg = '0;
		left_arg = '0;
		case (ctl.shift_type)
			SHIFT_ARITH: begin
				// Sign extends on the right, left shift same as logic
				right_arg = {(WIDTH - 1){data[WIDTH-1]}};
			end
			SHIFT_DOUBLE: begin
				right_arg = fill[WIDTH-2:0]; // Low bits of fill
				left_arg = fill[WIDTH-1:1];  // High bits of fill
			end
			SHIFT_CYCLIC: begin
				right_arg = data[WIDTH-2:0]; // Bits falling off the bottom
				left_arg = data[WIDTH-1:1];  // Bits falling off the top
			end
			default: begin
				// Logic shift keeps the zeros
			end
		endcase
	end

	// Amount zero passes straight through
	assign right_cand[0] = data;
	assign left_cand[0] = data;

	for (genvar i = 1; i < WIDTH; i++) begin : amount
		assign right_cand[i] = {right_arg[i-1:0], data[WIDTH-1:i]};
		assign left_cand[i] = {data[WIDTH-1-i:0], left_arg[WIDTH-2:WIDTH-1-i]};
	end

	// Amount multiplexer
	assign shifted = ctl.left ? left_cand[shamt] : right_cand[shamt];

endmodule

`default_nettype wire

//--- hdl/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_cfg.svh"

module issue_stage import alu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire alu_req_t req,
	output logic issued_valid,
	output alu_req_t issued,
	output word_t add_b, // b or its inverse
	output word_t cmp_a, // Compare operands, offset for signed mode
	output word_t cmp_b
);
	arith_ctl_t arith;  // Adder and comparator reading of the control word
	logic flip_sign;
	word_t sign_mask;

	assign arith = req.ctl.arith;

	// Flipping both MSBs maps signed order onto unsigned order
	assign flip_sign = arith.signed_mode && (req.unit == UNIT_CMP);
	assign sign_mask = {flip_sign, {(`ALU_WORD_WIDTH - 1){1'b0}}};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			issued_valid <= 1'b0;
		end else begin
			issued_valid <= in_valid;
		end
	end

	// Operands only move on a valid request
	always_ff @(posedge clk) begin
		if (in_valid) begin
			issued <= req;
			add_b <= arith.subtract ? ~req.b : req.b; // Carry in completes the negation
			cmp_a <= req.a ^ sign_mask;
			cmp_b <= req.b ^ sign_mask;
		end
	end

endmodule

`default_nettype wire

//--- hdl/result_stage.sv
`timescale 1ns/1ns
`default_nettype none

module result_stage import alu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire issued_valid,
	input wire unit_t unit,
	input wire word_t sum,
	input wire carry_out,
	input wire overflow,
	input wire above,
	input wire below,
	input wire word_t shifted,
	output logic out_valid,
	output alu_resp_t resp
);
	alu_resp_t next_resp;

	// Pick the answering block, unused flags stay low
	always_comb begin
		next_resp = '0;
		case (unit)
			UNIT_ADD: begin
				next_resp.result = sum;
				next_resp.carry = carry_out;
				next_resp.overflow = overflow;
			end
			UNIT_CMP: begin
				next_resp.above = above; // Result word stays zero
				next_resp.below = below;
			end
			UNIT_SHIFT: begin
				next_resp.result = shifted;
			end
			default: begin
			end
		endcase
		next_resp.zero = ~|next_resp.result;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
			resp <= '0;
		end else begin
			out_valid <= issued_valid;
			if (issued_valid) begin
				resp <= next_resp; // Holds the last response between requests
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_top import alu_pkg::*; (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire alu_req_t req,
	output logic out_valid,
	output alu_resp_t resp
);
	// Issue register outputs
	logic issued_valid;
	alu_req_t issued;
	word_t add_b;
	word_t cmp_a;
	word_t cmp_b;

	// Peer block outputs
	word_t sum;
	logic carry_out;
	logic overflow;
	logic above;
	logic below;
	word_t shifted;

	issue_stage issue0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.req(req),
		.issued_valid(issued_valid),
		.issued(issued),
		.add_b(add_b),
		.cmp_a(cmp_a),
		.cmp_b(cmp_b)
	);

	cla_adder adder0 (
		.a(issued.a),
		.b(add_b),
		.carry_in(issued.ctl.arith.carry_in),
		.sum(sum),
		.carry_out(carry_out),
		.overflow(overflow)
	);

	magnitude_comparator comparator0 (
		.a(cmp_a),
		.b(cmp_b),
		.above(above),
		.below(below)
	);

	// b doubles as the fill word
	polyshifter shifter0 (
		.data(issued.a),
		.fill(issued.b),
		.shamt(issued.shamt),
		.ctl(issued.ctl.shift),
		.shifted(shifted)
	);

	result_stage result0 (
		.clk(clk),
		.reset(reset),
		.issued_valid(issued_valid),
		.unit(issued.unit),
		.sum(sum),
		.carry_out(carry_out),
		.overflow(overflow),
		.above(above),
		.below(below),
		.shifted(shifted),
		.out_valid(out_valid),
		.resp(resp)
	);

endmodule

`default_nettype wire

//--- test/alu_tests.svh
`ifndef ALU_TESTS_SVH
`define ALU_TESTS_SVH

function automatic alu_req_t arith_req(input unit_t u, input logic sgn, input logic sub,
		input logic cin, input word_t a, input word_t b);
	alu_req_t r;
	r = '0;
	r.unit = u;
	r.ctl.arith.signed_mode = sgn;
	r.ctl.arith.subtract = sub;
	r.ctl.arith.carry_in = cin;
	r.a = a;
	r.b = b;
	return r;
endfunction

function automatic alu_req_t shift_req(input logic left, input shift_type_t kind,
		input word_t data, input word_t fill, input shamt_t amt);
	alu_req_t r;
	r = '0;
	r.unit = UNIT_SHIFT;
	r.ctl.shift.left = left;
	r.ctl.shift.shift_type = kind;
	r.a = data;
	r.b = fill;      // Fill word for double precision
	r.shamt = amt;
	return r;
endfunction

// Any unit, any control word
function automatic alu_req_t random_req();
	alu_req_t r;
	word_t bits;
	int u;
	u = int'(rand_bits(2)) % 3;
	bits = rand_bits(7);
	r.unit = unit_t'(u[1:0]);
	r.ctl = bits[2:0];
	r.shamt = shamt_t'(bits >> 3);
	r.a = rand_word();
	r.b = rand_word();
	return r;
endfunction

task automatic reset_test();
	start_test("reset");
	for (int i = 0; i < 4; i++) begin
		checks++;
		if (out_valid !== 1'b0) report_failure("out_valid high before any request");
		check_resp('0, resp);
		skip_slot();
	end
	finish_test();
endtask

task automatic add_test();
	start_test("add");
	for (int i = 0; i < 16; i++) begin
		issue(arith_req(UNIT_ADD, 1'b0, i[0], i[1], rand_word(), rand_word())); // Both carry ins
	end
	issue(arith_req(UNIT_ADD, 1'b0, 1'b0, 1'b0, 16'hffff, 16'h0001));  // Carry out, zero
	issue(arith_req(UNIT_ADD, 1'b0, 1'b0, 1'b0, 16'h7fff, 16'h0001));  // Signed overflow
	issue(arith_req(UNIT_ADD, 1'b0, 1'b1, 1'b1, 16'h8000, 16'h0001));
	issue(arith_req(UNIT_ADD, 1'b0, 1'b1, 1'b1, 16'h1234, 16'h1234));
	finish_test();
endtask

task automatic cmp_test();
	word_t a;
	start_test("compare");
	for (int i = 0; i < 12; i++) begin
		a = rand_word();
		issue(arith_req(UNIT_CMP, i[0], 1'b0, 1'b0, a, (i % 3 == 0) ? a : rand_word()));
	end
	// Opposite sign bits order differently when signed
	issue(arith_req(UNIT_CMP, 1'b0, 1'b0, 1'b0, 16'h8000, 16'h0001));
	issue(arith_req(UNIT_CMP, 1'b1, 1'b0, 1'b0, 16'h8000, 16'h0001));
	issue(arith_req(UNIT_CMP, 1'b0, 1'b0, 1'b0, 16'h7fff, 16'hffff));
	issue(arith_req(UNIT_CMP, 1'b1, 1'b0, 1'b0, 16'h7fff, 16'hffff));
	issue(arith_req(UNIT_CMP, 1'b1, 1'b0, 1'b0, 16'h8000, 16'h8000));
	finish_test();
endtask

task automatic shift_test();
	word_t data;
	start_test("shift");
	for (int dir = 0; dir < 2; dir++) begin
		for (int mode = 0; mode < 4; mode++) begin
			for (int amt = 0; amt < width; amt++) begin
				data = rand_word();
				if (mode == 1) data[width-1] = ~amt[0]; // Negative on even amounts
				issue(shift_req(dir[0], shift_type_t'(mode[1:0]), data, rand_word(), shamt_t'(amt)));
			end
		end
	end
	finish_test();
endtask

task automatic stream_test();
	start_test("stream");
	for (int i = 0; i < 40; i++) issue(random_req()); // in_valid never drops
	finish_test();
endtask

task automatic gap_test();
	start_test("gaps");
	for (int i = 0; i < 48; i++) begin
		if (rand_bits(1) != '0) begin
			issue(random_req());
		end else begin
			skip_slot();
		end
	end
	finish_test();
endtask

`endif

//--- test/alu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_cfg.svh"

module alu_tb import alu_pkg::*; ();
	localparam int width = `ALU_WORD_WIDTH;
	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	localparam int drain_limit = 8;
	// Requests or idle slots of the reset, add, cmp, shift, stream and gap tests
	localparam int slot_total = 4 + 20 + 17 + 2 * 4 * width + 40 + 48;
	localparam int timeout_ns = (reset_cycles + slot_total + 6 * drain_limit + 50) * clk_period;

	typedef logic [`ALU_SHAMT_WIDTH-1:0] shamt_t;
	typedef struct packed {
		alu_resp_t resp;
		int unsigned due; // Cycle count when out_valid must be seen
	} pending_t;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	alu_req_t req;
	logic out_valid;
	alu_resp_t resp;

	pending_t pending[$];                    // Expected responses in issue order
	int unsigned cycle = 0;                  // Rising edges so far
	logic [16:0] lfsr_state = 17'd72652;
	string test_name = "none";
	int tests = 0;
	int checks = 0;
	int errors = 0;
	int checks_at_start;
	int errors_at_start;

	alu_top dut0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.req(req),
		.out_valid(out_valid),
		.resp(resp)
	);

	initial begin
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// Taps of x^17 + x^14 + 1 with one step per bit taken
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[width-2:0], lfsr_state[16]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic word_t rand_word();
		return rand_bits(width);
	endfunction

	// Reference model of a response
	function automatic alu_resp_t expect_resp(input alu_req_t r);
		alu_resp_t e;
		word_t bb;
		word_t ext;                             // Word that feeds the vacated bits
		logic [width:0] total;
		logic [2*width-1:0] pair;
		e = '0;
		case (r.unit)
			UNIT_ADD: begin
				bb = r.ctl.arith.subtract ? ~r.b : r.b;
				total = {1'b0, r.a} + {1'b0, bb} + {{width{1'b0}}, r.ctl.arith.carry_in};
				e.result = total[width-1:0];
				e.carry = total[width];
				// Same operand signs but a different result sign
				e.overflow = (r.a[width-1] == bb[width-1])
					&& (e.result[width-1] != r.a[width-1]);
			end
			UNIT_CMP: begin
				if (r.ctl.arith.signed_mode) begin
					e.above = $signed(r.a) > $signed(r.b);
					e.below = $signed(r.a) < $signed(r.b);
				end else begin
					e.above = r.a > r.b;
					e.below = r.a < r.b;
				end
			end
			UNIT_SHIFT: begin
				case (r.ctl.shift.shift_type)
					SHIFT_ARITH: ext = r.ctl.shift.left ? '0 : {width{r.a[width-1]}};
					SHIFT_DOUBLE: ext = r.b;
					SHIFT_CYCLIC: ext = r.a;
					default: ext = '0;
				endcase
				if (r.ctl.shift.left) begin
					pair = {r.a, ext} << r.shamt;
					e.result = pair[2*width-1:width];
				end else begin
					pair = {ext, r.a} >> r.shamt;
					e.result = pair[width-1:0];
				end
			end
			default: begin
			end
		endcase
		e.zero = (e.result == '0);
		return e;
	endfunction

	task automatic report_failure(input string msg);
		errors++;
		$display("Error in %s: %s", test_name, msg);
	endtask

	task automatic check_word(input string field, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("** Error %s %s: expected %h, actual %h", test_name, field, expected, actual);
		end
	endtask

	task automatic check_resp(input alu_resp_t expected, input alu_resp_t actual);
		check_word("result", expected.result, actual.result);
		checks++;
		if ({expected.carry, expected.overflow, expected.above, expected.below, expected.zero}
				!== {actual.carry, actual.overflow, actual.above, actual.below, actual.zero}) begin
			errors++;
			$display("** Error %s flags c,v,a,b,z: expected %b%b%b%b%b, actual %b%b%b%b%b",
				test_name, expected.carry, expected.overflow, expected.above, expected.below,
				expected.zero, actual.carry, actual.overflow, actual.above, actual.below, actual.zero);
		end
	endtask

	// Outputs settle after the rising edge and are sampled mid cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (pending.size() > 0 && pending[0].due == cycle && !out_valid) begin
				report_failure("no out_valid two cycles after a request");
				void'(pending.pop_front());
			end else if (out_valid) begin
				if (pending.size() == 0 || pending[0].due != cycle) begin
					report_failure("out_valid high with no request two cycles before");
				end else begin
					check_resp(pending[0].resp, resp);
					void'(pending.pop_front());
				end
			end
		end
	end

	task automatic next_slot();
		@(posedge clk);
		#1;
	endtask

	task automatic issue(input alu_req_t r);
		pending_t p;
		req = r;
		in_valid = 1'b1;
		p.resp = expect_resp(r);
		p.due = cycle + 2;
		pending.push_back(p);
		next_slot();
	endtask

	task automatic skip_slot();
		in_valid = 1'b0;
		next_slot();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		for (int i = 0; i < drain_limit && pending.size() > 0; i++) skip_slot();
		tests++;
		$display("Test %s done: %0d checks, %0d errors", test_name,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	`include "alu_tests.svh"

	initial begin
		#(timeout_ns);
		$display("Watchdog expired after %0d ns, the run is stuck", timeout_ns);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		req = '0;
		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0;
		reset_test();
		add_test();
		cmp_test();
		shift_test();
		stream_test();
		gap_test();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
+incdir+test
hdl/alu_pkg.sv
hdl/cla_adder.sv
hdl/magnitude_comparator.sv
hdl/polyshifter.sv
hdl/issue_stage.sv
hdl/result_stage.sv
hdl/alu_top.sv
test/alu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0 -Wno-fatal
TOP = alu_tb
FILELIST = src.f
OBJ_DIR = obj_dir
PASS_MSG = Simulation passed

BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv hdl/*.svh test/*.sv test/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
